//--- sources.f
common/trap_pkg.sv
common/csr_port_if.sv
trap_ctrl/trap_ctrl.sv
timer_swi/timer_swi.sv
hdl/csr_file.sv
hdl/trap_top.sv
test/trap_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the trap unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module trap_tb -f sources.f -o trap_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/trap_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

//--- test/trap_tb.sv
// ------------------------------------------------
// trap unit testbench
// drives trap_top through ecall, illegal and load
// traps, timer interrupt, mret, masking and stall,
// and interrupt/exception priority
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module trap_tb;
    import trap_pkg::*;

    logic      clk;
    logic      rst_n;
    addr_t     inst_addr_i;
    xlen_t     inst_data_i;
    logic      inst_valid_i;
    logic      jump_flag_i;
    addr_t     jump_addr_i;
    logic      atom_busy_i;
    logic      ecall_i, ebreak_i, illegal_i;
    logic      fetch_misalign_i, load_misalign_i, store_misalign_i;
    logic      mret_i;
    logic      ext_irq_i;
    irq_id_t   irq_id_i;
    logic      core_we_i;
    csr_addr_t core_waddr_i;
    xlen_t     core_wdata_i;
    csr_addr_t csr_raddr_i;
    xlen_t     csr_rdata_o;
    logic      tmr_we_i;
    tmr_addr_t tmr_addr_i;
    xlen_t     tmr_wdata_i;
    xlen_t     tmr_rdata_o;
    logic      redirect_o;
    addr_t     redirect_addr_o;
    logic      flush_o;
    logic      stall_o;

    xlen_t     first_rnd;
    xlen_t     tvec;
    xlen_t     rd;
    xlen_t     word;
    addr_t     pc;
    addr_t     ret_pc;
    addr_t     target;
    irq_id_t   id;
    int        hold;

    trap_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------
    // checks and bus helpers
    // ------------------------------------------------
    task automatic check_eq(input string what, input xlen_t got, input xlen_t exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic csr_write(input csr_addr_t addr, input xlen_t data);
        @(posedge clk);
        core_we_i    <= 1'b1;
        core_waddr_i <= addr;
        core_wdata_i <= data;
        @(posedge clk);
        core_we_i    <= 1'b0;
    endtask

    task automatic csr_read(input csr_addr_t addr, output xlen_t data);
        @(posedge clk);
        csr_raddr_i <= addr;
        @(negedge clk);
        data = csr_rdata_o;
    endtask

    task automatic tmr_write(input tmr_addr_t addr, input xlen_t data);
        @(posedge clk);
        tmr_we_i    <= 1'b1;
        tmr_addr_i  <= addr;
        tmr_wdata_i <= data;
        @(posedge clk);
        tmr_we_i    <= 1'b0;
    endtask

    task automatic tmr_read(input tmr_addr_t addr, output xlen_t data);
        @(posedge clk);
        tmr_addr_i <= addr;
        @(negedge clk);
        data = tmr_rdata_o;
    endtask

    // flush rises the cycle after acceptance
    task automatic wait_accept(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (!flush_o) begin
            n++;
            if (n > max_cycles) timed_out("trap acceptance");
            @(negedge clk);
        end
    endtask

    // flush must hold until the one-cycle redirect
    task automatic wait_redirect(output addr_t addr);
        int n;
        n = 0;
        @(negedge clk);
        while (!redirect_o) begin
            check_eq("flush_o before redirect", {31'd0, flush_o}, 32'd1);
            n++;
            if (n > 200) timed_out("redirect");
            @(negedge clk);
        end
        addr = redirect_addr_o;
        @(negedge clk);
        check_eq("redirect_o one cycle later", {31'd0, redirect_o}, 32'd0);
    endtask

    task automatic expect_no_trap(input int cycles, input logic exp_stall);
        repeat (cycles) begin
            @(negedge clk);
            check_eq("redirect_o", {31'd0, redirect_o}, 32'd0);
            check_eq("flush_o", {31'd0, flush_o}, 32'd0);
            check_eq("stall_o", {31'd0, stall_o}, {31'd0, exp_stall});
        end
    endtask

    // exc bits: ecall, ebreak, fetch, load, store, illegal
    task automatic take_trap(input addr_t at_pc, input xlen_t data, input logic [5:0] exc,
                             input int max_cycles, output addr_t addr);
        @(posedge clk);
        inst_addr_i  <= at_pc;
        inst_data_i  <= data;
        inst_valid_i <= 1'b1;
        {ecall_i, ebreak_i, fetch_misalign_i, load_misalign_i, store_misalign_i,
         illegal_i} <= exc;
        wait_accept(max_cycles);
        @(posedge clk);
        inst_valid_i <= 1'b0;
        {ecall_i, ebreak_i, fetch_misalign_i, load_misalign_i, store_misalign_i,
         illegal_i} <= 6'b0;
        ext_irq_i    <= 1'b0;
        wait_redirect(addr);
    endtask

    // ------------------------------------------------
    // stimulus
    // ------------------------------------------------
    initial begin
        first_rnd = $urandom(32'h051c_8f97);
        rst_n = 1'b0;
        inst_addr_i = '0;
        inst_data_i = '0;
        inst_valid_i = 1'b0;
        jump_flag_i = 1'b0;
        jump_addr_i = '0;
        atom_busy_i = 1'b0;
        {ecall_i, ebreak_i, illegal_i} = 3'b0;
        {fetch_misalign_i, load_misalign_i, store_misalign_i} = 3'b0;
        mret_i = 1'b0;
        ext_irq_i = 1'b0;
        irq_id_i = '0;
        core_we_i = 1'b0;
        core_waddr_i = '0;
        core_wdata_i = '0;
        csr_raddr_i = '0;
        tmr_we_i = 1'b0;
        tmr_addr_i = '0;
        tmr_wdata_i = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        expect_no_trap(2, 1'b0);
        tmr_read(TMR_MTIMECMP, rd);
        check_eq("mtimecmp after reset", rd, 32'hffff_ffff);

        // ecall, direct mode
        tvec = first_rnd & 32'hffff_fff0;
        csr_write(CSR_MTVEC, tvec);
        csr_write(CSR_MSTATUS, 32'h0000_0008);
        pc = $urandom & 32'hffff_fffc;
        take_trap(pc, $urandom, 6'b100000, 20, target);
        check_eq("ecall redirect", target, tvec);
        csr_read(CSR_MEPC, rd);
        check_eq("ecall mepc", rd, pc);
        csr_read(CSR_MCAUSE, rd);
        check_eq("ecall mcause", rd, 32'd11);
        csr_read(CSR_MSTATUS, rd);
        check_eq("ecall mstatus", rd, 32'h0000_0080);

        // illegal instruction, then misaligned load
        word = $urandom;
        take_trap($urandom & 32'hffff_fffc, word, 6'b000001, 20, target);
        check_eq("illegal redirect", target, tvec);
        csr_read(CSR_MCAUSE, rd);
        check_eq("illegal mcause", rd, 32'd2);
        csr_read(CSR_MTVAL, rd);
        check_eq("illegal mtval", rd, word);
        word = $urandom;
        take_trap($urandom & 32'hffff_fffc, word, 6'b000100, 20, target);
        csr_read(CSR_MCAUSE, rd);
        check_eq("load misalign mcause", rd, 32'd4);
        csr_read(CSR_MTVAL, rd);
        check_eq("load misalign mtval", rd, word);

        // timer interrupt, vectored
        csr_write(CSR_MTVEC, tvec | 32'd1);
        tmr_read(TMR_MTIME, rd);
        tmr_write(TMR_MTIMECMP, rd + 32'd30);  // fires a few cycles out
        csr_write(CSR_MIE, 32'h0000_0080);
        csr_write(CSR_MSTATUS, 32'h0000_0008);
        pc = $urandom & 32'hffff_fffc;
        take_trap(pc, '0, 6'b000000, 200, target);
        check_eq("timer redirect", target, tvec + 32'd28);
        csr_read(CSR_MCAUSE, rd);
        check_eq("timer mcause", rd, 32'h8000_0007);
        csr_read(CSR_MEPC, rd);
        check_eq("timer mepc", rd, pc + 32'd4);
        tmr_write(TMR_MTIMECMP, 32'hffff_ffff);

        // ------------------------------------------------
        // mret and the fetch wait
        // ------------------------------------------------
        ret_pc = pc + 32'd4;
        @(posedge clk);
        inst_addr_i <= ret_pc ^ 32'h0000_0100;  // fetch not there yet
        mret_i      <= 1'b1;
        @(posedge clk);
        mret_i      <= 1'b0;
        wait_redirect(target);
        check_eq("mret redirect", target, ret_pc);
        csr_read(CSR_MSTATUS, rd);
        check_eq("mret mstatus", rd, 32'h0000_0088);
        hold = 3 + int'($urandom % 8);
        @(posedge clk);
        inst_valid_i <= 1'b1;
        ecall_i      <= 1'b1;
        expect_no_trap(hold, 1'b0);  // still in the wait
        @(posedge clk);
        inst_addr_i <= ret_pc;
        wait_accept(20);
        @(posedge clk);
        inst_valid_i <= 1'b0;
        ecall_i      <= 1'b0;
        wait_redirect(target);
        csr_read(CSR_MCAUSE, rd);
        check_eq("ecall after mret mcause", rd, 32'd11);

        // software interrupt: masked, stalled, then taken
        csr_write(CSR_MTVEC, tvec);
        tmr_write(TMR_MSIP, 32'd1);
        csr_write(CSR_MIE, 32'h0);
        csr_write(CSR_MSTATUS, 32'h0000_0008);
        pc = $urandom & 32'hffff_fffc;
        @(posedge clk);
        inst_addr_i  <= pc;
        inst_valid_i <= 1'b1;
        expect_no_trap(20, 1'b0);
        @(posedge clk);
        atom_busy_i <= 1'b1;
        csr_write(CSR_MIE, 32'h0000_0008);
        expect_no_trap(20, 1'b1);
        @(posedge clk);
        atom_busy_i <= 1'b0;
        take_trap(pc, '0, 6'b000000, 20, target);
        check_eq("soft redirect", target, tvec);
        csr_read(CSR_MCAUSE, rd);
        check_eq("soft mcause", rd, 32'h8000_0003);

        // ------------------------------------------------
        // priority
        // ------------------------------------------------
        csr_write(CSR_MIE, 32'h0000_0888);
        tmr_write(TMR_MTIMECMP, 32'd0);  // timer pending too
        id = irq_id_t'($urandom);
        @(posedge clk);
        ext_irq_i <= 1'b1;
        irq_id_i  <= id;
        csr_write(CSR_MSTATUS, 32'h0000_0008);
        take_trap($urandom & 32'hffff_fffc, '0, 6'b000000, 20, target);
        csr_read(CSR_MCAUSE, rd);
        check_eq("external mcause", rd, 32'h8000_0010 + {24'd0, id});
        csr_write(CSR_MSTATUS, 32'h0000_0008);
        @(posedge clk);
        ext_irq_i <= 1'b1;
        pc = $urandom & 32'hffff_fffc;
        take_trap(pc, '0, 6'b100000, 20, target);
        csr_read(CSR_MCAUSE, rd);
        check_eq("ecall over external mcause", rd, 32'd11);
        csr_read(CSR_MEPC, rd);
        check_eq("ecall over external mepc", rd, pc);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/trap_top.sv
// ------------------------------------------------
// trap top level
// machine trap sequencer, CSR file and timer block
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module trap_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    // pipeline
    input  wire trap_pkg::addr_t     inst_addr_i,
    input  wire trap_pkg::xlen_t     inst_data_i,
    input  wire logic                inst_valid_i,
    input  wire logic                jump_flag_i,
    input  wire trap_pkg::addr_t     jump_addr_i,
    input  wire logic                atom_busy_i,
    input  wire logic                ecall_i,
    input  wire logic                ebreak_i,
    input  wire logic                illegal_i,
    input  wire logic                fetch_misalign_i,
    input  wire logic                load_misalign_i,
    input  wire logic                store_misalign_i,
    input  wire logic                mret_i,
    input  wire logic                ext_irq_i,
    input  wire trap_pkg::irq_id_t   irq_id_i,
    // core CSR access
    input  wire logic                core_we_i,
    input  wire trap_pkg::csr_addr_t core_waddr_i,
    input  wire trap_pkg::xlen_t     core_wdata_i,
    input  wire trap_pkg::csr_addr_t csr_raddr_i,
    output trap_pkg::xlen_t          csr_rdata_o,
    // timer bus
    input  wire logic                tmr_we_i,
    input  wire trap_pkg::tmr_addr_t tmr_addr_i,
    input  wire trap_pkg::xlen_t     tmr_wdata_i,
    output trap_pkg::xlen_t          tmr_rdata_o,
    // to fetch and pipeline control
    output logic                     redirect_o,
    output trap_pkg::addr_t          redirect_addr_o,
    output logic                     flush_o,
    output logic                     stall_o
);

    logic timer_irq;
    logic soft_irq;

    csr_port_if csr_bus ();

    trap_ctrl u_trap_ctrl (
        .clk_i           (clk),
        .rst_n           (rst_n),
        .inst_addr_i     (inst_addr_i),
        .inst_data_i     (inst_data_i),
        .inst_valid_i    (inst_valid_i),
        .jump_flag_i     (jump_flag_i),
        .jump_addr_i     (jump_addr_i),
        .atom_busy_i     (atom_busy_i),
        .ecall_i         (ecall_i),
        .ebreak_i        (ebreak_i),
        .illegal_i       (illegal_i),
        .fetch_misalign_i(fetch_misalign_i),
        .load_misalign_i (load_misalign_i),
        .store_misalign_i(store_misalign_i),
        .mret_i          (mret_i),
        .ext_irq_i       (ext_irq_i),
        .irq_id_i        (irq_id_i),
        .timer_irq_i     (timer_irq),
        .soft_irq_i      (soft_irq),
        .csr             (csr_bus.trap),
        .redirect_o      (redirect_o),
        .redirect_addr_o (redirect_addr_o),
        .flush_o         (flush_o),
        .stall_o         (stall_o)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .trap        (csr_bus.csr),
        .core_we_i   (core_we_i),
        .core_waddr_i(core_waddr_i),
        .core_wdata_i(core_wdata_i),
        .csr_raddr_i (csr_raddr_i),
        .csr_rdata_o (csr_rdata_o)
    );

    timer_swi u_timer_swi (
        .clk        (clk),
        .rst_n      (rst_n),
        .tmr_we_i   (tmr_we_i),
        .tmr_addr_i (tmr_addr_i),
        .tmr_wdata_i(tmr_wdata_i),
        .tmr_rdata_o(tmr_rdata_o),
        .timer_irq_o(timer_irq),
        .soft_irq_o (soft_irq)
    );

endmodule

`default_nettype wire

//--- hdl/csr_file.sv
// ------------------------------------------------
// machine CSR file
// mstatus, mie, mtvec, mepc, mcause and mtval with a
// trap write port, a core write port and a
// combinational read port
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module csr_file (
    input  wire logic                clk,
    input  wire logic                rst_n,

    csr_port_if.csr                  trap,

    // core side
    input  wire logic                core_we_i,
    input  wire trap_pkg::csr_addr_t core_waddr_i,
    input  wire trap_pkg::xlen_t     core_wdata_i,
    input  wire trap_pkg::csr_addr_t csr_raddr_i,
    output trap_pkg::xlen_t          csr_rdata_o
);
    import trap_pkg::*;

    xlen_t     mstatus_q;
    xlen_t     mie_q;
    xlen_t     mtvec_q;
    xlen_t     mepc_q;
    xlen_t     mcause_q;
    xlen_t     mtval_q;

    logic      wr_en;
    csr_addr_t wr_addr;
    xlen_t     wr_data;

    // trap port wins, core write dropped that cycle
    assign wr_en   = trap.we | core_we_i;
    assign wr_addr = trap.we ? trap.waddr : core_waddr_i;
    assign wr_data = trap.we ? trap.wdata : core_wdata_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mtval_q   <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                CSR_MSTATUS: mstatus_q <= wr_data;
                CSR_MIE:     mie_q     <= wr_data;
                CSR_MTVEC:   mtvec_q   <= wr_data;
                CSR_MEPC:    mepc_q    <= {wr_data[31:2], 2'b00};  // word aligned
                CSR_MCAUSE:  mcause_q  <= wr_data;
                CSR_MTVAL:   mtval_q   <= wr_data;
                default: begin
                end
            endcase
        end
    end

    // ------------------------------------------------
    // read side
    // ------------------------------------------------
    always_comb begin
        case (csr_raddr_i)
            CSR_MSTATUS: csr_rdata_o = mstatus_q;
            CSR_MIE:     csr_rdata_o = mie_q;
            CSR_MTVEC:   csr_rdata_o = mtvec_q;
            CSR_MEPC:    csr_rdata_o = mepc_q;
            CSR_MCAUSE:  csr_rdata_o = mcause_q;
            CSR_MTVAL:   csr_rdata_o = mtval_q;
            default:     csr_rdata_o = '0;
        endcase
    end

    // values the trap sequencer works from
    assign trap.mstatus = mstatus_q;
    assign trap.mie     = mie_q;
    assign trap.mtvec   = mtvec_q;
    assign trap.mepc    = mepc_q;

endmodule

`default_nettype wire

//--- timer_swi/timer_swi.sv
// ------------------------------------------------
// machine timer and software interrupt
// 32-bit mtime, mtimecmp and msip behind a strobe
// register bus; raises the timer and soft lines
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module timer_swi (
    input  wire logic                clk,
    input  wire logic                rst_n,

    // register bus
    input  wire logic                tmr_we_i,
    input  wire trap_pkg::tmr_addr_t tmr_addr_i,
    input  wire trap_pkg::xlen_t     tmr_wdata_i,
    output trap_pkg::xlen_t          tmr_rdata_o,

    output logic                     timer_irq_o,
    output logic                     soft_irq_o
);
    import trap_pkg::*;

    xlen_t mtime_q;
    xlen_t mtimecmp_q;
    logic  msip_q;

    // ------------------------------------------------
    // registers
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;     // no timer irq out of reset
            msip_q     <= 1'b0;
        end else begin
            mtime_q <= mtime_q + 32'd1;
            if (tmr_we_i) begin
                case (tmr_addr_i)
                    TMR_MTIME:    mtime_q    <= tmr_wdata_i;  // write wins over count
                    TMR_MTIMECMP: mtimecmp_q <= tmr_wdata_i;
                    TMR_MSIP:     msip_q     <= tmr_wdata_i[0];
                    default: begin
                    end
                endcase
            end
        end
    end

    // combinational read, unmapped offsets give zero
    always_comb begin
        case (tmr_addr_i)
            TMR_MTIME:    tmr_rdata_o = mtime_q;
            TMR_MTIMECMP: tmr_rdata_o = mtimecmp_q;
            TMR_MSIP:     tmr_rdata_o = {31'd0, msip_q};
            default:      tmr_rdata_o = '0;
        endcase
    end

    // ------------------------------------------------
    // interrupt lines
    // ------------------------------------------------
    assign timer_irq_o = (mtime_q >= mtimecmp_q);  // level until cmp moves
    assign soft_irq_o  = msip_q;

endmodule

`default_nettype wire

//--- trap_ctrl/trap_ctrl.sv
// ------------------------------------------------
// trap sequencer
// picks the trap cause, saves pc and mtval, writes
// mepc/mstatus/mtval/mcause in order and sends the
// redirect to fetch; also handles mret
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module trap_ctrl (
    input  wire logic              clk_i,
    input  wire logic              rst_n,

    // pipeline
    input  wire trap_pkg::addr_t   inst_addr_i,
    input  wire trap_pkg::xlen_t   inst_data_i,
    input  wire logic              inst_valid_i,
    input  wire logic              jump_flag_i,
    input  wire trap_pkg::addr_t   jump_addr_i,
    input  wire logic              atom_busy_i,

    // exceptions and return
    input  wire logic              ecall_i,
    input  wire logic              ebreak_i,
    input  wire logic              illegal_i,
    input  wire logic              fetch_misalign_i,
    input  wire logic              load_misalign_i,
    input  wire logic              store_misalign_i,
    input  wire logic              mret_i,

    // interrupt lines
    input  wire logic              ext_irq_i,
    input  wire trap_pkg::irq_id_t irq_id_i,
    input  wire logic              timer_irq_i,
    input  wire logic              soft_irq_i,

    csr_port_if.trap               csr,

    output logic                   redirect_o,
    output trap_pkg::addr_t        redirect_addr_o,
    output logic                   flush_o,
    output logic                   stall_o
);
    import trap_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_MEPC,
        ST_MSTATUS,
        ST_MTVAL,
        ST_MCAUSE,
        ST_MRET_STATUS,
        ST_MRET_WAIT
    } state_e;

    state_e state_q;

    xlen_t cause_q;   // captured at acceptance
    xlen_t tval_q;
    addr_t epc_q;

    logic  ext_en;
    logic  tmr_en;
    logic  sw_en;
    logic  int_req;
    logic  exc_req;
    logic  req;
    logic  accept;
    logic  need_tval;
    xlen_t cause_d;
    xlen_t ent_status;
    xlen_t ret_status;
    addr_t vec_addr;
    addr_t tvec_base;

    // ------------------------------------------------
    // request decode
    // ------------------------------------------------
    assign ext_en  = ext_irq_i & csr.mie[MIE_MEIE];
    assign tmr_en  = timer_irq_i & csr.mie[MIE_MTIE];
    assign sw_en   = soft_irq_i & csr.mie[MIE_MSIE];
    assign int_req = (ext_en | tmr_en | sw_en) & csr.mstatus[MSTATUS_MIE];

    assign exc_req = ecall_i | ebreak_i | illegal_i
                   | fetch_misalign_i | load_misalign_i | store_misalign_i;
    assign req     = exc_req | int_req;
    assign accept  = req & inst_valid_i & ~atom_busy_i & (state_q == ST_IDLE);

    assign stall_o = req & atom_busy_i;  // only back-pressure
    assign flush_o = (state_q != ST_IDLE) && (state_q != ST_MRET_WAIT);

    // exceptions before interrupts, fixed order within each
    always_comb begin
        if (ecall_i) begin
            cause_d = CAUSE_ECALL;
        end else if (ebreak_i) begin
            cause_d = CAUSE_EBREAK;
        end else if (fetch_misalign_i) begin
            cause_d = CAUSE_FETCH_MISALIGN;
        end else if (load_misalign_i) begin
            cause_d = CAUSE_LOAD_MISALIGN;
        end else if (store_misalign_i) begin
            cause_d = CAUSE_STORE_MISALIGN;
        end else if (illegal_i) begin
            cause_d = CAUSE_ILLEGAL;
        end else if (ext_en) begin
            cause_d = CAUSE_INT_FLAG | (CAUSE_INT_EXT + {24'd0, irq_id_i});
        end else if (tmr_en) begin
            cause_d = CAUSE_INT_FLAG | CAUSE_INT_TIMER;
        end else begin
            cause_d = CAUSE_INT_FLAG | CAUSE_INT_SOFT;
        end
    end

    // cause, mtval and return pc
    always_ff @(posedge clk_i) begin
        if (accept) begin
            cause_q <= cause_d;
            tval_q  <= inst_data_i;
            if (exc_req) begin
                epc_q <= inst_addr_i;
            end else if (jump_flag_i) begin
                epc_q <= jump_addr_i;   // resume at the jump target
            end else begin
                epc_q <= inst_addr_i + 32'd4;
            end
        end
    end

    assign need_tval = (cause_q == CAUSE_ILLEGAL) || (cause_q == CAUSE_LOAD_MISALIGN)
                    || (cause_q == CAUSE_STORE_MISALIGN);

    // ------------------------------------------------
    // sequencer
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_MEPC;
                    end else if (mret_i) begin
                        state_q <= ST_MRET_STATUS;
                    end
                end
                ST_MEPC:        state_q <= ST_MSTATUS;
                ST_MSTATUS:     state_q <= need_tval ? ST_MTVAL : ST_MCAUSE;
                ST_MTVAL:       state_q <= ST_MCAUSE;
                ST_MCAUSE:      state_q <= ST_IDLE;
                ST_MRET_STATUS: state_q <= ST_MRET_WAIT;
                ST_MRET_WAIT: begin
                    if (inst_addr_i == redirect_addr_o) begin  // fetch has landed
                        state_q <= ST_IDLE;
                    end
                end
                default:        state_q <= ST_IDLE;
            endcase
        end
    end

    // mstatus images for entry and return
    always_comb begin
        ent_status               = csr.mstatus;
        ent_status[MSTATUS_MPIE] = csr.mstatus[MSTATUS_MIE];
        ent_status[MSTATUS_MIE]  = 1'b0;
        ret_status               = csr.mstatus;
        ret_status[MSTATUS_MIE]  = csr.mstatus[MSTATUS_MPIE];
        ret_status[MSTATUS_MPIE] = 1'b1;
    end

    // one CSR write per state
    always_comb begin
        csr.we    = 1'b1;
        csr.waddr = CSR_MEPC;
        csr.wdata = epc_q;
        case (state_q)
            ST_MEPC: begin
            end
            ST_MSTATUS: begin
                csr.waddr = CSR_MSTATUS;
                csr.wdata = ent_status;
            end
            ST_MTVAL: begin
                csr.waddr = CSR_MTVAL;
                csr.wdata = tval_q;
            end
            ST_MCAUSE: begin
                csr.waddr = CSR_MCAUSE;
                csr.wdata = cause_q;
            end
            ST_MRET_STATUS: begin
                csr.waddr = CSR_MSTATUS;
                csr.wdata = ret_status;
            end
            default: csr.we = 1'b0;
        endcase
    end

    // ------------------------------------------------
    // redirect
    // ------------------------------------------------
    assign tvec_base = {csr.mtvec[31:2], 2'b00};
    assign vec_addr  = (cause_q[31] && csr.mtvec[0])
                     ? tvec_base + {26'd0, cause_q[3:0], 2'b00}  // vectored
                     : tvec_base;

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            redirect_o      <= 1'b0;
            redirect_addr_o <= '0;
        end else begin
            redirect_o <= 1'b0;
            if (state_q == ST_MCAUSE) begin
                redirect_o      <= 1'b1;
                redirect_addr_o <= vec_addr;
            end else if (state_q == ST_MRET_STATUS) begin
                redirect_o      <= 1'b1;
                redirect_addr_o <= csr.mepc;
            end
        end
    end

endmodule

`default_nettype wire

//--- common/csr_port_if.sv
// ------------------------------------------------
// CSR port bundle
// trap sequencer write port plus the CSR values
// the sequencer needs to read back
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface csr_port_if;
    import trap_pkg::*;

    logic      we;     // single-cycle strobe
    csr_addr_t waddr;
    xlen_t     wdata;

    xlen_t mstatus;
    xlen_t mie;
    xlen_t mtvec;
    xlen_t mepc;

    modport trap (
        output we, waddr, wdata,
        input  mstatus, mie, mtvec, mepc
    );

    modport csr (
        input  we, waddr, wdata,
        output mstatus, mie, mtvec, mepc
    );

endinterface

`default_nettype wire

//--- common/trap_pkg.sv
// ------------------------------------------------
// trap package
// widths, machine CSR addresses, trap cause codes,
// mstatus/mie bit positions and timer offsets
// ------------------------------------------------
`default_nettype none

package trap_pkg;

    // ------------------------------------------------
    // vector types
    // ------------------------------------------------
    typedef logic [31:0] xlen_t;     // data word
    typedef logic [31:0] addr_t;     // instruction address
    typedef logic [11:0] csr_addr_t;
    typedef logic [7:0]  irq_id_t;   // external interrupt id
    typedef logic [3:0]  tmr_addr_t; // timer register offset

    // machine CSR addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MIE     = 12'h304;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;
    localparam csr_addr_t CSR_MTVAL   = 12'h343;

    // ------------------------------------------------
    // cause codes
    // ------------------------------------------------
    localparam xlen_t CAUSE_FETCH_MISALIGN = 32'd0;
    localparam xlen_t CAUSE_ILLEGAL        = 32'd2;
    localparam xlen_t CAUSE_EBREAK         = 32'd3;
    localparam xlen_t CAUSE_LOAD_MISALIGN  = 32'd4;
    localparam xlen_t CAUSE_STORE_MISALIGN = 32'd6;
    localparam xlen_t CAUSE_ECALL          = 32'd11;

    localparam xlen_t CAUSE_INT_FLAG  = 32'h8000_0000; // bit 31
    localparam xlen_t CAUSE_INT_SOFT  = 32'd3;
    localparam xlen_t CAUSE_INT_TIMER = 32'd7;
    localparam xlen_t CAUSE_INT_EXT   = 32'd16;        // plus the irq id

    // status and enable bit positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MIE_MSIE     = 3;
    localparam int MIE_MTIE     = 7;
    localparam int MIE_MEIE     = 11;

    // timer register offsets
    localparam tmr_addr_t TMR_MTIME    = 4'd0;
    localparam tmr_addr_t TMR_MTIMECMP = 4'd4;
    localparam tmr_addr_t TMR_MSIP     = 4'd8;

endpackage

`default_nettype wire
